/* tb.f */
+incdir+hw
hw/cp_pkg.sv
hw/stream_fifo.sv
hw/carry_tracker.sv
hw/ff_run_counter.sv
hw/byte_emitter.sv
hw/carry_propagation.sv
tests/carry_propagation_assert.sv
tests/tb_carry_propagation.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the carry propagation testbench with Verilator and runs it.
# The exit status is the simulation's own status.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_carry_propagation \
    -f tb.f \
    --Mdir obj_dir \
    -o tb_sim
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Build failed with status $build_status"
    exit $build_status
fi

./obj_dir/tb_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation failed with status $sim_status"
    exit $sim_status
fi

echo "Simulation finished"
exit 0

/* tests/tb_carry_propagation.sv */
// Testbench with clock, stimulus, reference model, output compare and watchdog
module tb_carry_propagation;

    typedef cp_pkg::chunk_t chunk_list_t[$];
    typedef cp_pkg::beat_t  beat_list_t[$];

    localparam int DRIVE_DELAY = 10;

    logic           clk;
    logic           rst_n;
    logic           in_valid;
    cp_pkg::chunk_t in_chunk;
    logic           in_ready;
    logic           out_valid;
    cp_pkg::byte_t  out_byte;
    logic           out_last;
    logic           out_ready;

    chunk_list_t    frame;
    beat_list_t     exp_q;
    beat_list_t     got_q;
    cp_pkg::beat_t  got_beat;
    cp_pkg::beat_t  exp_beat;
    string          cur_test;
    logic           random_mode;
    int unsigned    chunks_sent;
    int unsigned    cycle_count;
    int             n;

    carry_propagation u_carry_propagation (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_chunk  (in_chunk),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_byte  (out_byte),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

    always #50 clk = ~clk;

    // ----------------------------------------
    // Reference model and checking
    // ----------------------------------------

    function automatic beat_list_t expected_bytes(input chunk_list_t chunks);
        beat_list_t    result;
        cp_pkg::beat_t b;
        cp_pkg::byte_t held;
        logic          have_held;
        int            run;
        int            i;
        int            k;
        held      = '0;
        have_held = 1'b0;
        run       = 0;
        for (i = 0; i < chunks.size(); i++) begin
            if (!have_held) begin
                // Nothing precedes the first chunk of a frame, so its carry is lost
                held      = chunks[i].data;
                have_held = 1'b1;
            end else if (!chunks[i].carry && chunks[i].data == 8'hFF) begin
                run++;
            end else begin
                b.last = 1'b0;
                b.data = held + cp_pkg::byte_t'(chunks[i].carry);
                result.push_back(b);
                b.data = chunks[i].carry ? 8'h00 : 8'hFF;
                for (k = 0; k < run; k++) begin
                    result.push_back(b);
                end
                run  = 0;
                held = chunks[i].data;
            end
            if (chunks[i].last) begin
                // Flush goes out unchanged and the very last byte carries the frame end
                b.last = 1'b0;
                b.data = held;
                result.push_back(b);
                b.data = 8'hFF;
                for (k = 0; k < run; k++) begin
                    result.push_back(b);
                end
                b      = result[result.size() - 1];
                b.last = 1'b1;
                result[result.size() - 1] = b;
                have_held = 1'b0;
                run       = 0;
            end
        end
        return result;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [8:0] expected,
                               input logic [8:0] actual);
        string line;
        if (expected !== actual) begin
            line = $sformatf("Mismatch in %s: expected byte %h last %b, actual byte %h last %b",
                             name, expected[7:0], expected[8], actual[7:0], actual[8]);
            report_failure(line);
        end
    endtask

    // Bytes are taken at the falling edge, where the coming transfer is already settled
    always @(negedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            got_q.push_back(cp_pkg::beat_t'({out_last, out_byte}));
        end
    end

    always @(posedge clk) begin
        while (got_q.size() != 0) begin
            got_beat = got_q.pop_front();
            if (exp_q.size() == 0) begin
                report_failure($sformatf("Unexpected output byte %h in %s",
                                         got_beat.data, cur_test));
            end else begin
                exp_beat = exp_q.pop_front();
                check_value(cur_test, exp_beat, got_beat);
            end
        end
    end

    // Watchdog, the allowance grows with every chunk sent
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > 20 * chunks_sent + 200) begin
            report_failure("Output stalled, no result within the cycles allowed for the chunks");
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    always @(posedge clk) begin
        #DRIVE_DELAY;
        if (random_mode) begin
            out_ready = ($urandom_range(0, 3) != 0);
        end else begin
            out_ready = 1'b1;
        end
    end

    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic add_chunk(input logic carry, input cp_pkg::byte_t data, input logic last);
        cp_pkg::chunk_t c;
        c.last  = last;
        c.carry = carry;
        c.data  = data;
        frame.push_back(c);
    endtask

    task automatic add_random_frame(input int len);
        int            i;
        logic          carry;
        cp_pkg::byte_t data;
        for (i = 0; i < len; i++) begin
            carry = ($urandom_range(0, 3) == 0);
            // Plenty of 0xFF so that runs of several bytes form
            if ($urandom_range(0, 9) < 4) begin
                data = 8'hFF;
            end else begin
                data = cp_pkg::byte_t'($urandom_range(0, 255));
            end
            add_chunk(carry, data, i == len - 1);
        end
    endtask

    task automatic send_chunk(input cp_pkg::chunk_t c);
        int   gap;
        logic accepted;
        gap = random_mode ? int'($urandom_range(0, 3)) : 0;
        repeat (gap) step();
        in_valid = 1'b1;
        in_chunk = c;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = in_ready;
            step();
        end
        in_valid    = 1'b0;
        chunks_sent = chunks_sent + 1;
    endtask

    task automatic run_frame(input string name);
        beat_list_t expected;
        int         i;
        cur_test = name;
        expected = expected_bytes(frame);
        for (i = 0; i < expected.size(); i++) begin
            exp_q.push_back(expected[i]);
        end
        for (i = 0; i < frame.size(); i++) begin
            send_chunk(frame[i]);
        end
        frame.delete();
        while (exp_q.size() != 0) begin
            step();
        end
        repeat (5) step();
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_chunk    = '0;
        out_ready   = 1'b0;
        random_mode = 1'b0;
        chunks_sent = 0;
        cycle_count = 0;
        cur_test    = "reset";
        void'($urandom(95));
        repeat (5) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        step();

        add_chunk(1'b0, 8'h12, 1'b0);
        add_chunk(1'b0, 8'h34, 1'b0);
        add_chunk(1'b0, 8'h56, 1'b0);
        add_chunk(1'b0, 8'h78, 1'b0);
        add_chunk(1'b0, 8'h9A, 1'b1);
        run_frame("plain_bytes");

        // First carry has nothing to reach, the held 0xFF wraps to 0x00
        add_chunk(1'b1, 8'h40, 1'b0);
        add_chunk(1'b1, 8'h20, 1'b0);
        add_chunk(1'b1, 8'hFF, 1'b0);
        add_chunk(1'b1, 8'h30, 1'b1);
        run_frame("carry_into_held");

        add_chunk(1'b0, 8'h7F, 1'b0);
        add_chunk(1'b0, 8'hFF, 1'b0);
        add_chunk(1'b0, 8'hFF, 1'b0);
        add_chunk(1'b0, 8'hFF, 1'b0);
        add_chunk(1'b1, 8'h01, 1'b0);
        add_chunk(1'b0, 8'hFF, 1'b0);
        add_chunk(1'b0, 8'hFF, 1'b0);
        add_chunk(1'b0, 8'h02, 1'b1);
        run_frame("carry_over_run");

        add_chunk(1'b0, 8'h7F, 1'b0);
        add_chunk(1'b0, 8'hFF, 1'b0);
        add_chunk(1'b0, 8'hFF, 1'b0);
        add_chunk(1'b0, 8'hFF, 1'b0);
        add_chunk(1'b0, 8'h01, 1'b1);
        run_frame("run_without_carry");

        add_chunk(1'b0, 8'h33, 1'b0);
        add_chunk(1'b0, 8'hFF, 1'b0);
        add_chunk(1'b0, 8'hFF, 1'b0);
        add_chunk(1'b0, 8'hFF, 1'b1);
        run_frame("flush_pending_run");

        add_chunk(1'b0, 8'hFF, 1'b0);
        add_chunk(1'b0, 8'hFF, 1'b0);
        add_chunk(1'b0, 8'hFF, 1'b1);
        run_frame("flush_first_ff");

        add_chunk(1'b1, 8'h44, 1'b1);
        run_frame("single_chunk");

        // Random frames with input gaps and output back-pressure
        random_mode = 1'b1;
        for (n = 0; n < 8; n++) begin
            add_random_frame(int'($urandom_range(1, 24)));
            run_frame($sformatf("random_frame_%0d", n));
        end
        random_mode = 1'b0;
        repeat (10) step();

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* tests/carry_propagation_assert.sv */
// Concurrent handshake, reset and run limit checks bound to the carry propagation top level
module carry_propagation_assert (
    input logic          clk,
    input logic          rst_n,
    input logic          in_ready,
    input logic          out_valid,
    input cp_pkg::byte_t out_byte,
    input logic          out_last,
    input logic          out_ready,
    input cp_pkg::run_t  run_count,
    input logic          run_inc
);

    // An offered output byte holds until the consumer takes it
    out_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_byte) && $stable(out_last)))
        else $error("output byte changed or was dropped before it was accepted");

    // Both ends stay quiet once reset has been seen on a clock edge
    reset_quiet_a: assert property (@(posedge clk)
        (!rst_n && $past(!rst_n)) |-> (!in_ready && !out_valid))
        else $error("in_ready or out_valid high during reset");

    // ----------------------------------------
    // Run counter limit
    // ----------------------------------------

    // A further 0xFF at the top of the count would need a wider counter
    run_no_overflow_a: assert property (@(posedge clk) disable iff (!rst_n)
        (run_count == '1) |-> !run_inc)
        else $error("0xFF run longer than the counter can hold");

endmodule

bind carry_propagation carry_propagation_assert u_carry_propagation_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_byte  (out_byte),
    .out_last  (out_last),
    .out_ready (out_ready),
    .run_count (run_count),
    .run_inc   (run_inc)
);

/* hw/carry_propagation.sv */
// Top level of the carry propagation stage with input and output buffering
`include "cp_config.svh"

module carry_propagation (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           in_valid,
    input  cp_pkg::chunk_t in_chunk,
    output logic           in_ready,
    output logic           out_valid,
    output cp_pkg::byte_t  out_byte,
    output logic           out_last,
    input  logic           out_ready
);

    logic           chunk_valid;
    logic           chunk_ready;
    cp_pkg::chunk_t chunk;
    logic           beat_valid;
    logic           beat_ready;
    cp_pkg::beat_t  beat;
    cp_pkg::beat_t  out_beat;
    logic           load;
    logic           settle;
    logic           tracker_clear;
    cp_pkg::byte_t  load_byte;
    logic           carry;
    logic           held_valid;
    cp_pkg::byte_t  resolved_byte;
    cp_pkg::byte_t  fill_byte;
    logic           run_inc;
    logic           run_dec;
    logic           run_clear;
    cp_pkg::run_t   run_count;
    logic           run_empty;

    // ----------------------------------------
    // Input side
    // ----------------------------------------

    stream_fifo #(
        .payload_t (cp_pkg::chunk_t),
        .DEPTH     (`CP_IN_DEPTH)
    ) u_in_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_chunk),
        .in_ready  (in_ready),
        .out_valid (chunk_valid),
        .out_data  (chunk),
        .out_ready (chunk_ready)
    );

    // ----------------------------------------
    // Carry resolution
    // ----------------------------------------

    carry_tracker u_carry_tracker (
        .clk           (clk),
        .rst_n         (rst_n),
        .load          (load),
        .settle        (settle),
        .clear         (tracker_clear),
        .load_byte     (load_byte),
        .carry         (carry),
        .held_valid    (held_valid),
        .resolved_byte (resolved_byte),
        .fill_byte     (fill_byte)
    );

    // The count itself is watched by the run limit check
    ff_run_counter u_ff_run_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .inc       (run_inc),
        .dec       (run_dec),
        .clear     (run_clear),
        .count     (run_count),
        .run_empty (run_empty)
    );

    byte_emitter u_byte_emitter (
        .clk           (clk),
        .rst_n         (rst_n),
        .chunk_valid   (chunk_valid),
        .chunk         (chunk),
        .chunk_ready   (chunk_ready),
        .beat_valid    (beat_valid),
        .beat          (beat),
        .beat_ready    (beat_ready),
        .load          (load),
        .settle        (settle),
        .tracker_clear (tracker_clear),
        .load_byte     (load_byte),
        .carry         (carry),
        .held_valid    (held_valid),
        .resolved_byte (resolved_byte),
        .fill_byte     (fill_byte),
        .run_inc       (run_inc),
        .run_dec       (run_dec),
        .run_clear     (run_clear),
        .run_empty     (run_empty)
    );

    // ----------------------------------------
    // Output side
    // ----------------------------------------

    stream_fifo #(
        .payload_t (cp_pkg::beat_t),
        .DEPTH     (`CP_OUT_DEPTH)
    ) u_out_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (beat_valid),
        .in_data   (beat),
        .in_ready  (beat_ready),
        .out_valid (out_valid),
        .out_data  (out_beat),
        .out_ready (out_ready)
    );

    assign out_byte = out_beat.data;
    assign out_last = out_beat.last;

endmodule

/* hw/byte_emitter.sv */
// Chunk classifier and output sequencing FSM of the carry propagation stage
module byte_emitter (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           chunk_valid,
    input  cp_pkg::chunk_t chunk,
    output logic           chunk_ready,
    output logic           beat_valid,
    output cp_pkg::beat_t  beat,
    input  logic           beat_ready,
    output logic           load,
    output logic           settle,
    output logic           tracker_clear,
    output cp_pkg::byte_t  load_byte,
    output logic           carry,
    input  logic           held_valid,
    input  cp_pkg::byte_t  resolved_byte,
    input  cp_pkg::byte_t  fill_byte,
    output logic           run_inc,
    output logic           run_dec,
    output logic           run_clear,
    input  logic           run_empty
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_EMIT_HELD,
        ST_DRAIN,
        ST_FLUSH_HELD,
        ST_FLUSH_RUN
    } state_t;

    state_t        state;
    state_t        state_next;
    cp_pkg::byte_t pend_byte;
    logic          pend_last;
    logic          take;
    logic          is_plain_ff;

    assign chunk_ready = (state == ST_IDLE);
    assign take        = chunk_valid && chunk_ready;
    assign is_plain_ff = !chunk.carry && (chunk.data == 8'hFF);

    // ----------------------------------------
    // Next state and strobes
    // ----------------------------------------

    always_comb begin
        state_next    = state;
        load          = 1'b0;
        settle        = 1'b0;
        tracker_clear = 1'b0;
        load_byte     = chunk.data;
        carry         = 1'b0;
        run_inc       = 1'b0;
        run_dec       = 1'b0;
        run_clear     = 1'b0;
        beat_valid    = 1'b0;
        beat.last     = 1'b0;
        beat.data     = resolved_byte;
        case (state)
            ST_IDLE: begin
                if (take) begin
                    if (!held_valid) begin
                        // First chunk of a frame, its carry has nothing earlier to reach
                        load = 1'b1;
                        if (chunk.last) begin
                            settle     = 1'b1;
                            state_next = ST_FLUSH_HELD;
                        end
                    end else if (is_plain_ff) begin
                        run_inc = 1'b1;
                        if (chunk.last) begin
                            settle     = 1'b1;
                            state_next = ST_FLUSH_HELD;
                        end
                    end else begin
                        settle     = 1'b1;
                        carry      = chunk.carry;
                        state_next = ST_EMIT_HELD;
                    end
                end
            end
            ST_EMIT_HELD: begin
                beat_valid = 1'b1;
                if (beat_ready) begin
                    state_next = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                beat.data = fill_byte;
                if (run_empty) begin
                    // Run is out, the settling chunk's byte becomes the held byte
                    load      = 1'b1;
                    load_byte = pend_byte;
                    if (pend_last) begin
                        settle     = 1'b1;
                        state_next = ST_FLUSH_HELD;
                    end else begin
                        state_next = ST_IDLE;
                    end
                end else begin
                    beat_valid = 1'b1;
                    run_dec    = beat_ready;
                end
            end
            ST_FLUSH_HELD: begin
                // The run is counted down one step early here, so that
                // run_empty in ST_FLUSH_RUN marks the final byte of the frame
                beat_valid = 1'b1;
                beat.last  = run_empty;
                if (beat_ready) begin
                    if (run_empty) begin
                        tracker_clear = 1'b1;
                        run_clear     = 1'b1;
                        state_next    = ST_IDLE;
                    end else begin
                        run_dec    = 1'b1;
                        state_next = ST_FLUSH_RUN;
                    end
                end
            end
            ST_FLUSH_RUN: begin
                beat_valid = 1'b1;
                beat.data  = fill_byte;
                beat.last  = run_empty;
                if (beat_ready) begin
                    if (run_empty) begin
                        tracker_clear = 1'b1;
                        run_clear     = 1'b1;
                        state_next    = ST_IDLE;
                    end else begin
                        run_dec = 1'b1;
                    end
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    // ----------------------------------------
    // Registers
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            pend_last <= 1'b0;
        end else begin
            state <= state_next;
            if (take) begin
                pend_last <= chunk.last;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pend_byte <= chunk.data;
        end
    end

endmodule

/* hw/ff_run_counter.sv */
// Counter of the pending 0xFF run, counting up on arrival and down while draining
module ff_run_counter (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         inc,
    input  logic         dec,
    input  logic         clear,
    output cp_pkg::run_t count,
    output logic         run_empty
);

    localparam cp_pkg::run_t RUN_MAX = '1;

    assign run_empty = (count == '0);

    // ----------------------------------------
    // Count register
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (inc) begin
            // Holds at the top instead of wrapping
            if (count != RUN_MAX) begin
                count <= count + cp_pkg::run_t'(1);
            end
        end else if (dec) begin
            if (!run_empty) begin
                count <= count - cp_pkg::run_t'(1);
            end
        end
    end

endmodule

/* hw/carry_tracker.sv */
// Holder of the pending byte and the latched carry, giving resolved and fill bytes
module carry_tracker (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          load,
    input  logic          settle,
    input  logic          clear,
    input  cp_pkg::byte_t load_byte,
    input  logic          carry,
    output logic          held_valid,
    output cp_pkg::byte_t resolved_byte,
    output cp_pkg::byte_t fill_byte
);

    cp_pkg::byte_t held_byte;
    logic          carry_q;

    // ----------------------------------------
    // Control state
    // ----------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            held_valid <= 1'b0;
            carry_q    <= 1'b0;
        end else if (clear) begin
            // End of frame, the next chunk starts a fresh stream
            held_valid <= 1'b0;
            carry_q    <= 1'b0;
        end else begin
            if (load) begin
                held_valid <= 1'b1;
            end
            if (settle) begin
                carry_q <= carry;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            held_byte <= load_byte;
        end
    end

    // ----------------------------------------
    // Resolved outputs
    // ----------------------------------------

    // The carry ripples into the held byte modulo 256; a held 0xFF wraps to 0x00
    assign resolved_byte = held_byte + cp_pkg::byte_t'(carry_q);

    // A carry turns each pending 0xFF into 0x00
    assign fill_byte = carry_q ? '0 : '1;

endmodule

/* hw/stream_fifo.sv */
// Small valid/ready FIFO with a type parameter for its payload
module stream_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_next;
    logic             push;
    logic             pop;

    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign out_valid = (count != '0);

    // An empty FIFO shows a zero payload, so last never floats high
    assign out_data = out_valid ? mem[rd_ptr] : '0;

    always_comb begin
        count_next = count;
        case ({push, pop})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            in_ready <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;
            // Registered so that it stays low through reset and drops on full
            in_ready <= (count_next != CNT_W'(DEPTH));
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

/* hw/cp_pkg.sv */
// Byte, chunk, output beat and run count types of the carry propagation stage
`include "cp_config.svh"

package cp_pkg;

    // ----------------------------------------
    // Data types
    // ----------------------------------------

    typedef logic [`CP_BYTE_W-1:0] byte_t;

    typedef logic [`CP_RUN_W-1:0] run_t;

    // One coder chunk: the carry belongs to the bytes already produced,
    // the data byte is the newest byte of the stream
    typedef struct packed {
        logic  last;
        logic  carry;
        byte_t data;
    } chunk_t;

    // One resolved output byte, last marks the end of a frame
    typedef struct packed {
        logic  last;
        byte_t data;
    } beat_t;

endpackage

/* hw/cp_config.svh */
// Width and depth constants for the carry propagation stage
`ifndef CP_CONFIG_SVH
`define CP_CONFIG_SVH

// ----------------------------------------
// Data widths
// ----------------------------------------

// One byte of the coded output stream
`define CP_BYTE_W 8

// Pending 0xFF run counter, enough for a run of 255 bytes
`define CP_RUN_W 8

// ----------------------------------------
// Buffer depths
// ----------------------------------------

// Input chunks waiting for the emitter
`define CP_IN_DEPTH 4

// Resolved bytes waiting for the consumer
`define CP_OUT_DEPTH 4

`endif
